// ==== include/decode_config.svh ====
// width and encoding macros for the decode stage
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// register and operand width
`define DATA_W 64

// instruction word width, also the width of the decoded immediate
`define INSTR_W 32

// register number width
`define REG_IDX_W 5

// entries in the integer register file
`define REG_COUNT 32

// decoded op code, funct3 sitting above the 7-bit major opcode
`define OP_W 10

// op code carried by a bubble
// funct3 zero on the FENCE major opcode
`define NOP_OP 10'b000_0001111

`endif

// ==== hdl/decode_pkg.sv ====
// major opcode enumeration and packed record types of the decode stage
`include "decode_config.svh"

package decode_pkg;

    // major opcodes of the base integer set
    // named after the format they select
    typedef enum logic [6:0] {
        opc_r        = 7'b0110011,
        opc_r_word   = 7'b0111011,
        opc_jalr     = 7'b1100111,
        opc_load     = 7'b0000011,
        opc_imm      = 7'b0010011,
        opc_imm_word = 7'b0011011,
        opc_store    = 7'b0100011,
        opc_branch   = 7'b1100011,
        opc_lui      = 7'b0110111,
        opc_auipc    = 7'b0010111,
        opc_jal      = 7'b1101111,
        opc_fence    = 7'b0001111,
        opc_system   = 7'b1110011
    } opcode_e;

    // combinational result of the field decoder
    typedef struct packed {
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic [`OP_W-1:0]      op;
        // sign-extended except for U format
        logic [`INSTR_W-1:0]   imm;
        logic                  uses_rs1;
        logic                  uses_rs2;
        // major opcode is one of the thirteen above
        logic                  known;
    } decoded_instr_t;

    // write-back port into the register file
    typedef struct packed {
        logic                  en;
        logic [`REG_IDX_W-1:0] rd;
        logic [`DATA_W-1:0]    data;
    } wb_write_t;

    // registered decode output record
    typedef struct packed {
        logic                  valid;
        logic [`DATA_W-1:0]    pc;
        logic [`INSTR_W-1:0]   instr;
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`OP_W-1:0]      op;
        logic [`INSTR_W-1:0]   imm;
        logic [`DATA_W-1:0]    data_a;
        logic [`DATA_W-1:0]    data_b;
    } decode_out_t;

endpackage

// ==== hdl/instr_field_decoder.sv ====
// combinational instruction field decoder with register numbers, immediate and op code
`timescale 1ns/1ps
`include "decode_config.svh"

module instr_field_decoder (
    input  logic [`INSTR_W-1:0]        instr,
    output decode_pkg::decoded_instr_t dec
);
    import decode_pkg::*;

    // raw fields, fixed positions in every format
    opcode_e               major;
    logic [2:0]            funct3;
    logic [`REG_IDX_W-1:0] rs1_f;
    logic [`REG_IDX_W-1:0] rs2_f;
    logic [`REG_IDX_W-1:0] rd_f;

    // one candidate immediate per format
    logic [`INSTR_W-1:0] imm_i;
    logic [`INSTR_W-1:0] imm_s;
    logic [`INSTR_W-1:0] imm_b;
    logic [`INSTR_W-1:0] imm_u;
    logic [`INSTR_W-1:0] imm_j;

    // unlisted encodings fall through to the default arm
    assign major  = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];
    assign rd_f   = instr[11:7];

    // I format, 12 bits straight from the top
    assign imm_i = {{20{instr[31]}}, instr[31:20]};

    // S format, split around rd position
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // B format, halfword offset so bit 0 is zero
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};

    // U format, upper 20 bits, no extension needed at 32 bits
    assign imm_u = {instr[31:12], 12'b0};

    // J format, scrambled 20-bit offset, halfword aligned
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        // start from nothing read and nothing written
        dec     = '0;
        dec.op  = {funct3, instr[6:0]};

        case (major)
            // register-register, full and word width
            opc_r, opc_r_word: begin
                dec.rs1      = rs1_f;
                dec.rs2      = rs2_f;
                dec.rd       = rd_f;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.known    = 1'b1;
            end

            // I format group
            // rs2 slot holds immediate bits here, never a register
            opc_jalr, opc_load, opc_imm, opc_imm_word, opc_system: begin
                dec.rs1      = rs1_f;
                dec.rd       = rd_f;
                dec.imm      = imm_i;
                dec.uses_rs1 = 1'b1;
                dec.known    = 1'b1;
            end

            // store, base in rs1 and data in rs2, no destination
            opc_store: begin
                dec.rs1      = rs1_f;
                dec.rs2      = rs2_f;
                dec.imm      = imm_s;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.known    = 1'b1;
            end

            // conditional branch compares rs1 with rs2
            opc_branch: begin
                dec.rs1      = rs1_f;
                dec.rs2      = rs2_f;
                dec.imm      = imm_b;
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.known    = 1'b1;
            end

            // upper immediates, no funct3 field in this format
            opc_lui, opc_auipc: begin
                dec.rd    = rd_f;
                dec.op    = {3'b000, instr[6:0]};
                dec.imm   = imm_u;
                dec.known = 1'b1;
            end

            // jump and link, destination only
            opc_jal: begin
                dec.rd    = rd_f;
                dec.op    = {3'b000, instr[6:0]};
                dec.imm   = imm_j;
                dec.known = 1'b1;
            end

            // fence carries pred/succ bits in the I slot
            // no register read or written
            opc_fence: begin
                dec.imm   = imm_i;
                dec.known = 1'b1;
            end

            // unknown major opcode, everything stays cleared
            default: begin
                dec.known = 1'b0;
            end
        endcase
    end

    // unknown opcode must never claim a source, or it could raise a stall
    always_comb begin
        assert (dec.known || !(dec.uses_rs1 || dec.uses_rs2))
            else $error("source-use flag set on unknown opcode %h", instr[6:0]);
    end

endmodule

// ==== hdl/register_file.sv ====
// integer register file, one write port, two combinational read ports, x0 held at zero
`timescale 1ns/1ps
`include "decode_config.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  decode_pkg::wb_write_t  wb,
    input  logic [`REG_IDX_W-1:0]  rd_idx_a,
    input  logic [`REG_IDX_W-1:0]  rd_idx_b,
    output logic [`DATA_W-1:0]     rd_data_a,
    output logic [`DATA_W-1:0]     rd_data_b
);

    // architectural registers x0..x31
    logic [`DATA_W-1:0] regs [`REG_COUNT];

    // write lands on the edge
    // x0 writes dropped here and nowhere else
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // reads straight from the array
    // same-cycle write is not forwarded, old value seen
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    // x0 stays zero through any write-back sequence
    a_x0_zero: assert property (
        @(posedge clk) disable iff (reset) regs[0] == '0
    ) else $error("register x0 holds nonzero value %h", regs[0]);

endmodule

// ==== hdl/decode_stage.sv ====
// decode stage top with hazard check, bubble insertion and the decode output register
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`INSTR_W-1:0]     instr,
    input  logic [`DATA_W-1:0]      pc,
    // destination of the instruction now in the ALU, zero when none
    input  logic [`REG_IDX_W-1:0]   alu_dest,
    input  decode_pkg::wb_write_t   wb,
    output logic                    stall,
    output decode_pkg::decode_out_t out
);
    import decode_pkg::*;

    decoded_instr_t     dec;
    logic [`DATA_W-1:0] data_a;
    logic [`DATA_W-1:0] data_b;

    // per-source hazard hits
    logic hit_rs1;
    logic hit_rs2;

    // load a bubble instead of the decoded instruction
    logic bubble;

    decode_out_t out_next;

    // empty slot in the output register
    // only op is nonzero, it reads as a fence
    function automatic decode_out_t bubble_rec();
        decode_out_t r;
        r    = '0;
        r.op = `NOP_OP;
        return r;
    endfunction

    instr_field_decoder u_field_dec (
        .instr (instr),
        .dec   (dec)
    );

    // read indices come straight from the decoder
    // write-back passes through untouched, even during stall
    register_file u_regfile (
        .clk       (clk),
        .reset     (reset),
        .wb        (wb),
        .rd_idx_a  (dec.rs1),
        .rd_idx_b  (dec.rs2),
        .rd_data_a (data_a),
        .rd_data_b (data_b)
    );

    // only sources the instruction really reads can collide
    assign hit_rs1 = dec.uses_rs1 && (dec.rs1 == alu_dest);
    assign hit_rs2 = dec.uses_rs2 && (dec.rs2 == alu_dest);

    // ALU result not ready yet, upstream holds instr and pc
    assign stall = dec.known && (alu_dest != '0) && (hit_rs1 || hit_rs2);

    // unknown opcode is dropped without holding upstream
    assign bubble = stall || !dec.known;

    // next output record
    always_comb begin
        out_next = bubble_rec();
        if (!bubble) begin
            out_next.valid  = 1'b1;
            out_next.pc     = pc;
            out_next.instr  = instr;
            out_next.rd     = dec.rd;
            out_next.rs1    = dec.rs1;
            out_next.op     = dec.op;
            out_next.imm    = dec.imm;
            out_next.data_a = data_a;
            out_next.data_b = data_b;
        end
    end

    // one edge from instr to out
    always_ff @(posedge clk) begin
        if (reset) begin
            out <= bubble_rec();
        end else begin
            out <= out_next;
        end
    end

    // stalled instruction must not also leave the stage
    a_stall_bubble: assert property (
        @(posedge clk) disable iff (reset) stall |=> !out.valid
    ) else $error("out.valid high after a stall cycle");

endmodule

// ==== verification/decode_vectors.svh ====
// stimulus row type and the decode stage vector table
// columns: instr, pc, alu_dest, wb_en, wb_rd, then expected stall, valid, rd, rs1, op, imm
// wb data is random and filled in by the testbench loop

typedef struct packed {
    logic [`INSTR_W-1:0]   instr;
    logic [`DATA_W-1:0]    pc;
    logic [`REG_IDX_W-1:0] alu_dest;
    logic                  wb_en;
    logic [`REG_IDX_W-1:0] wb_rd;
    logic                  exp_stall;
    logic                  exp_valid;
    logic [`REG_IDX_W-1:0] exp_rd;
    logic [`REG_IDX_W-1:0] exp_rs1;
    logic [`OP_W-1:0]      exp_op;
    logic [`INSTR_W-1:0]   exp_imm;
} vec_t;

localparam int NUM_VECS = 22;

vec_t vectors [NUM_VECS] = '{
    // addi x0 as filler while write-back fills x1, x2, x5
    '{32'h00000013, 64'h10000, 5'd0,  1'b1, 5'd1,  1'b0, 1'b1, 5'd0,  5'd0, 10'h013, 32'h00000000},
    '{32'h00000013, 64'h10004, 5'd0,  1'b1, 5'd2,  1'b0, 1'b1, 5'd0,  5'd0, 10'h013, 32'h00000000},
    '{32'h00000013, 64'h10008, 5'd0,  1'b1, 5'd5,  1'b0, 1'b1, 5'd0,  5'd0, 10'h013, 32'h00000000},
    // write to x0 must be dropped
    '{32'h00000013, 64'h1000c, 5'd0,  1'b1, 5'd0,  1'b0, 1'b1, 5'd0,  5'd0, 10'h013, 32'h00000000},
    // add x3, x1, x2
    '{32'h002081b3, 64'h10010, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd3,  5'd1, 10'h033, 32'h00000000},
    // sub x4, x5, x0, second operand reads zero
    '{32'h40028233, 64'h10014, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd4,  5'd5, 10'h033, 32'h00000000},
    // addi x6, x1, -5
    '{32'hffb08313, 64'h10018, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd6,  5'd1, 10'h013, 32'hfffffffb},
    // ld x7, 16(x2)
    '{32'h01013383, 64'h1001c, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd7,  5'd2, 10'h183, 32'h00000010},
    // sd x2, -8(x1)
    '{32'hfe20bc23, 64'h10020, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd0,  5'd1, 10'h1a3, 32'hfffffff8},
    // beq x1, x2, -4
    '{32'hfe208ee3, 64'h10024, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd0,  5'd1, 10'h063, 32'hfffffffc},
    // lui x8, alu_dest matches the unused rs1 slot
    '{32'h12345437, 64'h10028, 5'd8,  1'b0, 5'd0,  1'b0, 1'b1, 5'd8,  5'd0, 10'h037, 32'h12345000},
    // auipc x9, funct3 slot forced to zero
    '{32'hfffff497, 64'h1002c, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd9,  5'd0, 10'h017, 32'hfffff000},
    // jal x1, -8
    '{32'hff9ff0ef, 64'h10030, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd1,  5'd0, 10'h06f, 32'hfffffff8},
    // add hits on rs2, bubble goes out
    '{32'h002081b3, 64'h10034, 5'd2,  1'b0, 5'd0,  1'b1, 1'b0, 5'd0,  5'd0, 10'h00f, 32'h00000000},
    // same add held upstream, hazard gone
    '{32'h002081b3, 64'h10034, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd3,  5'd1, 10'h033, 32'h00000000},
    // addi with alu_dest on the rs2 slot, no stall
    '{32'hffb08313, 64'h10038, 5'd27, 1'b0, 5'd0,  1'b0, 1'b1, 5'd6,  5'd1, 10'h013, 32'hfffffffb},
    // addi stalls on rs1 while x10 is written
    '{32'hffb08313, 64'h1003c, 5'd1,  1'b1, 5'd10, 1'b1, 1'b0, 5'd0,  5'd0, 10'h00f, 32'h00000000},
    '{32'hffb08313, 64'h1003c, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd6,  5'd1, 10'h013, 32'hfffffffb},
    // add x11, x5, x10 with x5 rewritten in the same cycle
    '{32'h00a285b3, 64'h10040, 5'd0,  1'b1, 5'd5,  1'b0, 1'b1, 5'd11, 5'd5, 10'h033, 32'h00000000},
    // same read one cycle later sees the new x5
    '{32'h00a285b3, 64'h10044, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd11, 5'd5, 10'h033, 32'h00000000},
    // unknown major opcode, rs1 slot equal to alu_dest
    '{32'h0002807f, 64'h10048, 5'd5,  1'b0, 5'd0,  1'b0, 1'b0, 5'd0,  5'd0, 10'h00f, 32'h00000000},
    // fence, valid but carrying the bubble op code
    '{32'h0ff0000f, 64'h1004c, 5'd0,  1'b0, 5'd0,  1'b0, 1'b1, 5'd0,  5'd0, 10'h00f, 32'h000000ff}
};

// ==== verification/tb_decode_stage.sv ====
// testbench for the decode stage with clock, reset, vector loop, shadow registers and checks
`timescale 1ns/1ps
`include "decode_config.svh"

module tb_decode_stage;
    import decode_pkg::*;

    logic                  clk;
    logic                  reset;
    logic [`INSTR_W-1:0]   instr;
    logic [`DATA_W-1:0]    pc;
    logic [`REG_IDX_W-1:0] alu_dest;
    wb_write_t             wb;
    logic                  stall;
    decode_out_t           out;

    // vector table and its row type
    `include "decode_vectors.svh"

    // expected register contents
    logic [`DATA_W-1:0] shadow [`REG_COUNT];

    integer seed;

    decode_stage dut (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .pc       (pc),
        .alu_dest (alu_dest),
        .wb       (wb),
        .stall    (stall),
        .out      (out)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // compare one field against its expected value
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // second source register as read by the DUT
    // only R, R-word, store and branch read rs2, else index zero
    function automatic logic [`REG_IDX_W-1:0] source_b(input logic [`INSTR_W-1:0] ins);
        case (ins[6:0])
            7'b0110011, 7'b0111011, 7'b0100011, 7'b1100011: source_b = ins[24:20];
            default: source_b = '0;
        endcase
    endfunction

    initial begin
        vec_t               row;
        logic [`DATA_W-1:0] wdata;
        logic [`DATA_W-1:0] exp_a;
        logic [`DATA_W-1:0] exp_b;

        seed       = 32'ha356;
        clk        = 1'b0;
        reset      = 1'b1;
        instr      = '0;
        pc         = '0;
        alu_dest   = '0;
        wb         = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            shadow[r] = '0;
        end

        // reset over 16 rising edges
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
        end
        reset = 1'b0;

        // empty stage straight out of reset
        check_value("out.valid", 1'b0, out.valid);
        check_value("out.op", `NOP_OP, out.op);
        check_value("stall", 1'b0, stall);

        for (int i = 0; i < NUM_VECS; i++) begin
            row = vectors[i];
            wdata[63:32] = $random(seed);
            wdata[31:0]  = $random(seed);

            // drive on the falling edge
            instr    = row.instr;
            pc       = row.pc;
            alu_dest = row.alu_dest;
            wb.en    = row.wb_en;
            wb.rd    = row.wb_rd;
            wb.data  = wdata;

            // operands come from the registers before this write lands
            if (row.exp_valid) begin
                exp_a = shadow[row.exp_rs1];
                exp_b = shadow[source_b(row.instr)];
            end else begin
                exp_a = '0;
                exp_b = '0;
            end
            if (row.wb_en && (row.wb_rd != '0)) begin
                shadow[row.wb_rd] = wdata;
            end

            // one rising edge later, inputs still held
            @(negedge clk);
            check_value("stall", row.exp_stall, stall);
            check_value("out.valid", row.exp_valid, out.valid);
            check_value("out.pc", row.exp_valid ? row.pc : '0, out.pc);
            check_value("out.instr", row.exp_valid ? row.instr : '0, out.instr);
            check_value("out.rd", row.exp_rd, out.rd);
            check_value("out.rs1", row.exp_rs1, out.rs1);
            check_value("out.op", row.exp_op, out.op);
            check_value("out.imm", row.exp_imm, out.imm);
            check_value("out.data_a", exp_a, out.data_a);
            check_value("out.data_b", exp_b, out.data_b);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
+incdir+verification
hdl/decode_pkg.sv
hdl/instr_field_decoder.sv
hdl/register_file.sv
hdl/decode_stage.sv
verification/tb_decode_stage.sv

// ==== Makefile ====
# Verilator flow for the decode stage

OBJ = obj_dir

.PHONY: lint sim clean

# RTL lint from the top level down
lint:
	verilator --lint-only -Wall --timing --assert -f sim.f --top-module decode_stage

# build and run the testbench, pass only when the pass line is printed
sim:
	verilator --binary --timing --assert -j 0 -f sim.f \
		--top-module tb_decode_stage -Mdir $(OBJ)
	@result="$$(./$(OBJ)/Vtb_decode_stage)"; \
	echo "$$result"; \
	echo "$$result" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ)
